//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module rv32_decode_stage_tb \
    -f rv32_decode_stage.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vrv32_decode_stage_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi
exit 0

//--- rv32_ctrl_pkg.sv
package rv32_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic [2:0] {
        CLASS_ALU,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_BRANCH,
        CLASS_JAL,
        CLASS_JALR
    } instr_class_t;

    typedef enum logic [1:0] {
        SRC_A_RS1,
        SRC_A_PC,
        SRC_A_ZERO
    } src_a_t;

    typedef enum logic {
        SRC_B_RS2,
        SRC_B_IMM
    } src_b_t;

endpackage

//--- rv32_dec_if.sv
`timescale 1ns/1ns

interface rv32_dec_if
    import rv32_ctrl_pkg::*;
#(
    parameter int XLEN = 32
) ();

    alu_op_t         alu_op;
    instr_class_t    instr_class;
    src_a_t          src_a;
    src_b_t          src_b;
    logic [XLEN-1:0] imm;
    logic [2:0]      funct3;      // Kept for branch / load / store width
    logic [4:0]      rd;
    logic            illegal;

    modport producer (
        output alu_op, instr_class, src_a, src_b, imm, funct3, rd, illegal
    );

    modport consumer (
        input alu_op, instr_class, src_a, src_b, imm, funct3, rd, illegal
    );

endinterface

//--- rv32_decode_stage.f
rv32_isa_pkg.sv
rv32_ctrl_pkg.sv
rv32_dec_if.sv
rv32_instr_decoder.sv
rv32_reg_file.sv
rv32_operand_stage.sv
rv32_decode_stage.sv
rv32_decode_stage_tb.sv

//--- rv32_decode_stage.sv
`timescale 1ns/1ns

module rv32_decode_stage
    import rv32_isa_pkg::*;
    import rv32_ctrl_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            arst_n_i,

    input  logic            instr_valid_i,
    output logic            instr_ready_o,
    input  rv32_instr_t     instr_i,
    input  logic [XLEN-1:0] pc_i,

    input  logic            wb_en_i,
    input  logic [4:0]      wb_addr_i,
    input  logic [XLEN-1:0] wb_data_i,

    output logic            issue_valid_o,
    input  logic            issue_ready_i,
    output alu_op_t         alu_op_o,
    output instr_class_t    class_o,
    output logic [2:0]      funct3_o,
    output logic [4:0]      rd_o,
    output logic [XLEN-1:0] op_a_o,
    output logic [XLEN-1:0] op_b_o,
    output logic [XLEN-1:0] store_data_o,
    output logic [XLEN-1:0] pc_o,
    output logic            illegal_o
);

    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    rv32_dec_if #(.XLEN(XLEN)) dec_bus ();

    rv32_instr_decoder u_decoder (
        .instr_i (instr_i),
        .dec     (dec_bus.producer)
    );

    rv32_reg_file #(.XLEN(XLEN)) u_reg_file (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (instr_i.r.rs1),
        .rs2_addr_i (instr_i.r.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_en_i    (wb_en_i),
        .wb_addr_i  (wb_addr_i),
        .wb_data_i  (wb_data_i)
    );

    rv32_operand_stage #(.XLEN(XLEN)) u_operand_stage (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .in_valid_i   (instr_valid_i),
        .in_ready_o   (instr_ready_o),
        .pc_i         (pc_i),
        .dec          (dec_bus.consumer),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .out_valid_o  (issue_valid_o),
        .out_ready_i  (issue_ready_i),
        .alu_op_o     (alu_op_o),
        .class_o      (class_o),
        .funct3_o     (funct3_o),
        .rd_o         (rd_o),
        .op_a_o       (op_a_o),
        .op_b_o       (op_b_o),
        .store_data_o (store_data_o),
        .pc_o         (pc_o),
        .illegal_o    (illegal_o)
    );

endmodule

//--- rv32_decode_stage_tb.sv
`timescale 1ns/1ns

module rv32_decode_stage_tb;

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_VEC      = 64;

    logic        clk = 1'b0;
    logic        arst_n_i;
    logic        instr_valid_i;
    logic        instr_ready_o;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic        wb_en_i;
    logic [4:0]  wb_addr_i;
    logic [31:0] wb_data_i;
    logic        issue_valid_o;
    logic        issue_ready_i;
    logic [3:0]  alu_op_o;
    logic [2:0]  class_o;
    logic [2:0]  funct3_o;
    logic [4:0]  rd_o;
    logic [31:0] op_a_o;
    logic [31:0] op_b_o;
    logic [31:0] store_data_o;
    logic [31:0] pc_o;
    logic        illegal_o;

    // W: address, data   D: instruction, pc
    logic [7:0]  vec_kind   [MAX_VEC];
    logic [31:0] vec_first  [MAX_VEC];
    logic [31:0] vec_second [MAX_VEC];
    logic [31:0] exp_alu    [MAX_VEC];
    logic [31:0] exp_class  [MAX_VEC];
    logic [31:0] exp_f3     [MAX_VEC];
    logic [31:0] exp_rd     [MAX_VEC];
    logic [31:0] exp_op_a   [MAX_VEC];
    logic [31:0] exp_op_b   [MAX_VEC];
    logic [31:0] exp_store  [MAX_VEC];
    logic [31:0] exp_ill    [MAX_VEC];
    int          exp_q[$];              // Pending decodes, oldest first
    int          n_vec = 0;
    int          cycles = 0;
    int          limit = 1000;
    int          idx;
    logic        wb_pending = 1'b0;
    logic [4:0]  pend_addr;
    logic [31:0] pend_data;
    logic        stalled = 1'b0;
    logic        reg_full = 1'b0;       // Expected output register occupancy
    logic        exp_ready;
    logic [144:0] held;

    rv32_decode_stage #(.XLEN(32)) UUT (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .wb_en_i       (wb_en_i),
        .wb_addr_i     (wb_addr_i),
        .wb_data_i     (wb_data_i),
        .issue_valid_o (issue_valid_o),
        .issue_ready_i (issue_ready_i),
        .alu_op_o      (alu_op_o),
        .class_o       (class_o),
        .funct3_o      (funct3_o),
        .rd_o          (rd_o),
        .op_a_o        (op_a_o),
        .op_b_o        (op_b_o),
        .store_data_o  (store_data_o),
        .pc_o          (pc_o),
        .illegal_o     (illegal_o)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            abort_run($sformatf("MISMATCH time=%0t %s got=%h expected=%h",
                                $time, name, got, exp));
    endtask

    function automatic logic [144:0] out_bundle();
        return {issue_valid_o, alu_op_o, class_o, funct3_o, rd_o, op_a_o, op_b_o,
                store_data_o, pc_o, illegal_o};
    endfunction

    task automatic load_vectors();
        int fd;
        int code;
        logic [7:0] tag;
        logic [8*160-1:0] rest;
        fd = $fopen("rv32_decode_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open rv32_decode_vectors.txt");
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "#") begin
                    code = $fgets(rest, fd);     // Column description
                end else if (tag == "W") begin
                    code = $fscanf(fd, "%h %h", vec_first[n_vec], vec_second[n_vec]);
                    if (code != 2) abort_run("Malformed writeback line in vector file");
                    vec_kind[n_vec] = tag;
                    n_vec++;
                end else if (tag == "D") begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h",
                                   vec_first[n_vec], vec_second[n_vec], exp_alu[n_vec],
                                   exp_class[n_vec], exp_f3[n_vec], exp_rd[n_vec],
                                   exp_op_a[n_vec], exp_op_b[n_vec], exp_store[n_vec],
                                   exp_ill[n_vec]);
                    if (code != 10) abort_run("Malformed decode line in vector file");
                    vec_kind[n_vec] = tag;
                    exp_q.push_back(n_vec);
                    n_vec++;
                end else begin
                    abort_run("Unknown line type in vector file");
                end
            end
            $fclose(fd);
        end
    endtask

    // ##############################
    // Stimulus, all on falling edge
    // ##############################
    task automatic step();
        @(negedge clk);
        wb_en_i       = 1'b0;
        issue_ready_i = ($urandom % 4) != 0;   // Low about one cycle in four
    endtask

    task automatic send_write(input int k);
        step();
        instr_valid_i = 1'b0;
        wb_en_i       = 1'b1;
        wb_addr_i     = vec_first[k][4:0];
        wb_data_i     = vec_second[k];
    endtask

    // A write held back for this decode lands in its accept cycle
    task automatic send_decode(input int k);
        logic accept;
        accept = 1'b0;
        while (!accept) begin
            step();
            instr_valid_i = 1'b1;
            instr_i       = vec_first[k];
            pc_i          = vec_second[k];
            accept        = !reg_full || issue_ready_i;
            if (accept && wb_pending) begin
                wb_en_i    = 1'b1;
                wb_addr_i  = pend_addr;
                wb_data_i  = pend_data;
                wb_pending = 1'b0;
            end
        end
    endtask

    initial begin
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        wb_en_i       = 1'b0;
        wb_addr_i     = '0;
        wb_data_i     = '0;
        issue_ready_i = 1'b0;
        void'($urandom(32'h16b4_c922));
        load_vectors();
        limit = 4 * n_vec + 50;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n_i = 1'b1;
        for (int k = 0; k < n_vec; k++) begin
            if (vec_kind[k] == "D") begin
                send_decode(k);
            end else if ((k + 1 < n_vec) && (vec_kind[k + 1] == "D")) begin
                wb_pending = 1'b1;               // Bypass case
                pend_addr  = vec_first[k][4:0];
                pend_data  = vec_second[k];
            end else begin
                send_write(k);
            end
        end
        step();
        instr_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            step();
        end
        if (!issue_valid_o) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run("Output still valid after the last expected instruction");
        end
    end

    // ##############################
    // Output monitor
    // ##############################
    always @(negedge clk) begin
        if (arst_n_i) begin
            #(PERIOD / 4);
            exp_ready = !reg_full || issue_ready_i;
            check_field("issue_valid_o", 32'(issue_valid_o), 32'(reg_full));
            check_field("instr_ready_o", 32'(instr_ready_o), 32'(exp_ready));
            if (stalled) begin
                assert (out_bundle() === held) else
                    abort_run($sformatf("MISMATCH time=%0t %s got=%h expected=%h",
                                        $time, "outputs_while_stalled", out_bundle(),
                                        held));
            end
            if (issue_valid_o && issue_ready_i) begin
                if (exp_q.size() == 0) begin
                    abort_run("Output transfer seen with no decode outstanding");
                end else begin
                    idx = exp_q.pop_front();
                    check_field("alu_op_o", 32'(alu_op_o), exp_alu[idx]);
                    check_field("class_o", 32'(class_o), exp_class[idx]);
                    check_field("funct3_o", 32'(funct3_o), exp_f3[idx]);
                    check_field("rd_o", 32'(rd_o), exp_rd[idx]);
                    check_field("op_a_o", op_a_o, exp_op_a[idx]);
                    check_field("op_b_o", op_b_o, exp_op_b[idx]);
                    check_field("store_data_o", store_data_o, exp_store[idx]);
                    check_field("pc_o", pc_o, vec_second[idx]);
                    check_field("illegal_o", 32'(illegal_o), exp_ill[idx]);
                end
            end
            stalled  = issue_valid_o && !issue_ready_i;
            held     = out_bundle();
            reg_full = (instr_valid_i && exp_ready) || (reg_full && !issue_ready_i);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            abort_run($sformatf("Timeout after %0d cycles, %0d instructions not delivered",
                                cycles, exp_q.size()));
        end
    end

endmodule

//--- rv32_decode_vectors.txt
# W wb_addr wb_data
# D instr pc alu_op class funct3 rd op_a op_b store_data illegal
W 00 deadbeef
W 01 00000005
W 02 fffffff0
W 03 12345678
D 00208233 00000100 0 0 0 04 00000005 fffffff0 fffffff0 0
D 402082b3 00000104 1 0 0 05 00000005 fffffff0 fffffff0 0
D 00112333 00000108 3 0 2 06 fffffff0 00000005 00000005 0
D 401153b3 0000010c 7 0 5 07 fffffff0 00000005 00000005 0
D 0001c433 00000110 5 0 4 08 12345678 00000000 00000000 0
D 0030f4b3 00000114 9 0 7 09 00000005 12345678 12345678 0
D ffd08513 00000118 0 0 0 0a 00000005 fffffffd 00000000 0
D 0081a583 0000011c 0 1 2 0b 12345678 00000008 00000000 0
D fe20ae23 00000120 0 2 2 1c 00000005 fffffffc fffffff0 0
D fe208ce3 00000124 1 3 0 19 00000005 fffffff0 fffffff0 0
D 80001637 00000128 0 0 1 0c 00000000 80001000 00000000 0
D 12345697 0000012c 0 0 5 0d 0000012c 12345000 12345678 0
D ff1ff0ef 00000130 0 4 7 01 00000130 fffffff0 00000000 0
D 004182e7 00000134 0 5 0 05 12345678 00000004 00000000 0
D 40315713 00000138 7 0 5 0e fffffff0 00000003 12345678 0
D 00315793 0000013c 6 0 5 0f fffffff0 00000003 12345678 0
D 00000073 00000140 0 0 0 00 00000000 00000000 00000000 1
D 4010c1b3 00000144 5 0 4 03 00000000 00000000 00000000 1
W 10 cafef00d
D 010808b3 00000148 0 0 0 11 cafef00d cafef00d cafef00d 0

//--- rv32_instr_decoder.sv
`timescale 1ns/1ns

module rv32_instr_decoder
    import rv32_isa_pkg::*;
    import rv32_ctrl_pkg::*;
(
    input  rv32_instr_t         instr_i,
    rv32_dec_if.producer        dec
);

    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] shamt;
    logic        f7_zero;
    logic        f7_alt;
    logic        f3_shift;

    // Same funct3 to ALU mapping for OP and OP-IMM
    function automatic alu_op_t alu_of(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: alu_of = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_of = ALU_SLL;
            F3_SLT:     alu_of = ALU_SLT;
            F3_SLTU:    alu_of = ALU_SLTU;
            F3_XOR:     alu_of = ALU_XOR;
            F3_SRL_SRA: alu_of = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_of = ALU_OR;
            F3_AND:     alu_of = ALU_AND;
        endcase
    endfunction

    // ############################
    // Immediate formats
    // ############################
    assign imm_i = {{21{instr_i.i.sign}}, instr_i.i.b30_25, instr_i.i.b24_21, instr_i.i.b20};
    assign imm_s = {{21{instr_i.i.sign}}, instr_i.i.b30_25, instr_i.i.b11_8, instr_i.i.b7};
    assign imm_b = {{20{instr_i.i.sign}}, instr_i.i.b7, instr_i.i.b30_25,
                    instr_i.i.b11_8, 1'b0};
    assign imm_u = {instr_i.i.sign, instr_i.i.b30_25, instr_i.i.b24_21, instr_i.i.b20,
                    instr_i.i.b19_12, 12'b0};
    assign imm_j = {{12{instr_i.i.sign}}, instr_i.i.b19_12, instr_i.i.b20,
                    instr_i.i.b30_25, instr_i.i.b24_21, 1'b0};
    assign shamt = {27'b0, instr_i.r.rs2};

    assign f7_zero  = (instr_i.r.funct7 == F7_ZERO);
    assign f7_alt   = (instr_i.r.funct7 == F7_SUB_SRA);
    assign f3_shift = (instr_i.r.funct3 == F3_SLL) || (instr_i.r.funct3 == F3_SRL_SRA);

    assign dec.funct3 = instr_i.r.funct3;
    assign dec.rd     = instr_i.r.rd;

    // ############################
    // Control decode
    // ############################
    always_comb begin
        dec.alu_op      = ALU_ADD;
        dec.instr_class = CLASS_ALU;
        dec.src_a       = SRC_A_RS1;
        dec.src_b       = SRC_B_IMM;
        dec.imm         = imm_i;
        dec.illegal     = 1'b0;

        case (instr_i.r.opcode)
            OPCODE_LUI: begin
                dec.src_a = SRC_A_ZERO;
                dec.imm   = imm_u;
            end
            OPCODE_AUIPC: begin
                dec.src_a = SRC_A_PC;
                dec.imm   = imm_u;
            end
            OPCODE_JAL: begin
                dec.instr_class = CLASS_JAL;
                dec.src_a       = SRC_A_PC;
                dec.imm         = imm_j;
            end
            OPCODE_JALR: begin
                dec.instr_class = CLASS_JALR;
                dec.illegal     = (instr_i.r.funct3 != F3_JALR);
            end
            OPCODE_BRANCH: begin
                dec.instr_class = CLASS_BRANCH;
                dec.alu_op      = ALU_SUB;  // Compare by subtraction
                dec.src_b       = SRC_B_RS2;
                dec.imm         = imm_b;
                dec.illegal     = !(instr_i.r.funct3 inside
                                    {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU});
            end
            OPCODE_LOAD: begin
                dec.instr_class = CLASS_LOAD;
                dec.illegal     = !(instr_i.r.funct3 inside
                                    {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU});
            end
            OPCODE_STORE: begin
                dec.instr_class = CLASS_STORE;
                dec.imm         = imm_s;
                dec.illegal     = !(instr_i.r.funct3 inside {F3_SB, F3_SH, F3_SW});
            end
            OPCODE_OP_IMM: begin
                // No SUBI, funct7 only matters for shifts
                dec.alu_op = alu_of(instr_i.r.funct3,
                                    f7_alt && (instr_i.r.funct3 == F3_SRL_SRA));
                if (f3_shift) begin
                    dec.imm     = shamt;
                    dec.illegal = !(f7_zero || (f7_alt && (instr_i.r.funct3 == F3_SRL_SRA)));
                end
            end
            OPCODE_OP: begin
                dec.alu_op  = alu_of(instr_i.r.funct3, f7_alt);
                dec.src_b   = SRC_B_RS2;
                dec.imm     = '0;
                dec.illegal = !(f7_zero || (f7_alt && (instr_i.r.funct3 inside
                                                       {F3_ADD_SUB, F3_SRL_SRA})));
            end
            default: begin
                dec.src_a   = SRC_A_ZERO;
                dec.imm     = '0;
                dec.illegal = 1'b1;     // FENCE, SYSTEM and the rest
            end
        endcase
    end

endmodule

//--- rv32_isa_pkg.sv
package rv32_isa_pkg;

    // ############################
    // Major opcodes
    // ############################
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;

    // ############################
    // Funct3 per group
    // ############################
    localparam logic [2:0] F3_JALR    = 3'b000;

    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;

    localparam logic [2:0] F3_LB      = 3'b000;
    localparam logic [2:0] F3_LH      = 3'b001;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_LBU     = 3'b100;
    localparam logic [2:0] F3_LHU     = 3'b101;

    localparam logic [2:0] F3_SB      = 3'b000;
    localparam logic [2:0] F3_SH      = 3'b001;
    localparam logic [2:0] F3_SW      = 3'b010;

    localparam logic [2:0] F3_ADD_SUB = 3'b000; // Shared by OP and OP-IMM
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_ZERO    = 7'b0000000;
    localparam logic [6:0] F7_SUB_SRA = 7'b0100000; // Bit 30 selects SUB / SRA

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv32_rtype_t;

    // Slices that the immediate formats are assembled from
    typedef struct packed {
        logic       sign;
        logic [5:0] b30_25;
        logic [3:0] b24_21;
        logic       b20;
        logic [7:0] b19_12;
        logic [3:0] b11_8;
        logic       b7;
        logic [6:0] opcode;
    } rv32_immbits_t;

    typedef union packed {
        rv32_rtype_t   r;
        rv32_immbits_t i;
    } rv32_instr_t;

endpackage

//--- rv32_operand_stage.sv
`timescale 1ns/1ns

module rv32_operand_stage
    import rv32_ctrl_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            in_valid_i,
    output logic            in_ready_o,
    input  logic [XLEN-1:0] pc_i,
    rv32_dec_if.consumer    dec,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    output logic            out_valid_o,
    input  logic            out_ready_i,
    output alu_op_t         alu_op_o,
    output instr_class_t    class_o,
    output logic [2:0]      funct3_o,
    output logic [4:0]      rd_o,
    output logic [XLEN-1:0] op_a_o,
    output logic [XLEN-1:0] op_b_o,
    output logic [XLEN-1:0] store_data_o,
    output logic [XLEN-1:0] pc_o,
    output logic            illegal_o
);

    logic [XLEN-1:0] op_a_d;
    logic [XLEN-1:0] op_b_d;
    logic            load;

    // ############################
    // Operand select
    // ############################
    always_comb begin
        case (dec.src_a)
            SRC_A_RS1: op_a_d = rs1_data_i;
            SRC_A_PC:  op_a_d = pc_i;
            default:   op_a_d = '0;
        endcase
        op_b_d = (dec.src_b == SRC_B_IMM) ? dec.imm : rs2_data_i;
    end

    // Register empties this cycle or is already empty
    assign in_ready_o = !out_valid_o || out_ready_i;
    assign load       = in_valid_i && in_ready_o;

    // ############################
    // Output register
    // ############################
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_valid_o  <= 1'b0;
            alu_op_o     <= ALU_ADD;
            class_o      <= CLASS_ALU;
            funct3_o     <= '0;
            rd_o         <= '0;
            op_a_o       <= '0;
            op_b_o       <= '0;
            store_data_o <= '0;
            pc_o         <= '0;
            illegal_o    <= 1'b0;
        end else begin
            if (in_ready_o) begin
                out_valid_o <= in_valid_i;
            end
            if (load) begin
                alu_op_o     <= dec.alu_op;
                class_o      <= dec.instr_class;
                funct3_o     <= dec.funct3;
                rd_o         <= dec.rd;
                op_a_o       <= dec.illegal ? '0 : op_a_d;     // Illegal carries no operands
                op_b_o       <= dec.illegal ? '0 : op_b_d;
                store_data_o <= dec.illegal ? '0 : rs2_data_i;
                pc_o         <= pc_i;
                illegal_o    <= dec.illegal;
            end
        end
    end

    a_stall_stable : assert property (@(posedge clk) disable iff (!arst_n_i)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(alu_op_o)
            && $stable(class_o) && $stable(funct3_o) && $stable(rd_o)
            && $stable(op_a_o) && $stable(op_b_o) && $stable(store_data_o)
            && $stable(pc_o) && $stable(illegal_o)));

endmodule

//--- rv32_reg_file.sv
`timescale 1ns/1ns

module rv32_reg_file #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic [4:0]      rs1_addr_i,
    input  logic [4:0]      rs2_addr_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o,
    input  logic            wb_en_i,
    input  logic [4:0]      wb_addr_i,
    input  logic [XLEN-1:0] wb_data_i
);

    logic [XLEN-1:0] regs_q [1:31];   // x0 has no storage

    // Write data wins over the array for the same address
    function automatic logic [XLEN-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end
        if (wb_en_i && (wb_addr_i == addr)) begin
            return wb_data_i;
        end
        return regs_q[addr];
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_en_i && (wb_addr_i != 5'd0)) begin
            regs_q[wb_addr_i] <= wb_data_i;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

    a_x0_zero : assert property (@(posedge clk) disable iff (!arst_n_i)
        (rs1_addr_i == 5'd0) |-> (rs1_data_o == '0));

endmodule
